// ==== Bender.yml ====
package:
  name: lif_neuron

sources:
  - include_dirs:
      - .
    files:
      - neuron_pkg.sv
      - fp_add_sub.sv
      - potential_decay.sv
      - potential_adder.sv
      - lif_neuron_regs.sv
      - lif_neuron.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lif_neuron.sv

// ==== fp_add_sub.sv ====
// single-precision add/subtract, truncating, flush-to-zero, with exception flag
`timescale 1ns/1ps

module fp_add_sub
    import neuron_pkg::*;
(
    input  fp32_t a,
    input  fp32_t b,
    input  logic  sub,
    output fp32_t result,
    output logic  exception
);

    logic        a_sign;
    logic        b_sign;
    logic [7:0]  a_exp;
    logic [7:0]  b_exp;
    logic [23:0] a_man;
    logic [23:0] b_man;
    logic        a_special;
    logic        b_special;
    logic        swap;
    logic        big_sign;
    logic        small_sign;
    logic [7:0]  big_exp;
    logic [7:0]  small_exp;
    logic [23:0] big_man;
    logic [23:0] small_man;
    logic [7:0]  exp_diff;
    logic [23:0] small_aligned;
    logic [24:0] sum;
    logic [4:0]  lz;
    logic [9:0]  norm_exp;
    logic [23:0] norm_man;
    logic        overflow;

    // ****************************************
    // unpack
    // ****************************************
    // b sign flipped for subtract
    assign a_sign = a[31];
    assign b_sign = b[31] ^ sub;
    assign a_exp  = a[30:23];
    assign b_exp  = b[30:23];
    // exponent 0 counts as zero, no hidden bit
    assign a_man  = (a_exp == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
    assign b_man  = (b_exp == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
    // inf or nan operand
    assign a_special = (a_exp == 8'hff);
    assign b_special = (b_exp == 8'hff);

    // larger magnitude goes first, zeros compare as 0
    assign swap = {b_exp, b_man} > {a_exp, a_man};

    assign big_sign   = swap ? b_sign : a_sign;
    assign small_sign = swap ? a_sign : b_sign;
    assign big_exp    = swap ? b_exp : a_exp;
    assign small_exp  = swap ? a_exp : b_exp;
    assign big_man    = swap ? b_man : a_man;
    assign small_man  = swap ? a_man : b_man;

    // ****************************************
    // align and add
    // ****************************************
    assign exp_diff = big_exp - small_exp;
    // bits shifted out are dropped
    assign small_aligned = (exp_diff > 8'd23) ? 24'd0 : (small_man >> exp_diff);

    // big >= small so the difference never goes negative
    assign sum = (big_sign == small_sign) ? ({1'b0, big_man} + {1'b0, small_aligned})
                                          : ({1'b0, big_man} - {1'b0, small_aligned});

    // leading zero search over the low 24 bits, highest set bit wins
    always_comb begin
        lz = 5'd0;
        for (int i = 0; i < 24; i++) begin
            if (sum[i]) begin
                lz = 5'(23 - i);
            end
        end
    end

    // carry out shifts right, otherwise shift left by lz
    always_comb begin
        if (sum[24]) begin
            norm_man = sum[24:1];
            norm_exp = {2'b00, big_exp} + 10'd1;
        end else begin
            norm_man = sum[23:0] << lz;
            norm_exp = {2'b00, big_exp} - {5'd0, lz};
        end
    end

    // ****************************************
    // pack
    // ****************************************
    always_comb begin
        overflow = 1'b0;
        if (a_special || b_special) begin
            // infinity with the sign of the larger operand
            result = {big_sign, 8'hff, 23'd0};
        end else if (sum == 25'd0 || norm_exp[9] || norm_exp == 10'd0) begin
            // cancellation or underflow, flushed to +0
            result = '0;
        end else if (norm_exp >= 10'd255) begin
            overflow = 1'b1;
            result   = {big_sign, 8'hff, 23'd0};
        end else begin
            result = {big_sign, norm_exp[7:0], norm_man[22:0]};
        end
    end

    assign exception = a_special | b_special | overflow;

endmodule

// ==== lif_neuron.sv ====
// lif neuron top: apb registers around the leak and integrate-and-fire datapath
`timescale 1ns/1ps

module lif_neuron
    import neuron_pkg::*;
(
    input  logic        clk_adder,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        spike
);

    // register block to datapath
    fp32_t        potential;
    fp32_t        weight;
    fp32_t        threshold;
    decay_shift_t decay_shift;
    // datapath back to register block
    fp32_t        decayed;
    logic         decay_exception;
    fp32_t        next_potential;
    logic         fire;
    logic         add_exception;

    lif_neuron_regs u_regs (
        .clk_adder       (clk_adder),
        .rst_n           (rst_n),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .potential       (potential),
        .weight          (weight),
        .threshold       (threshold),
        .decay_shift     (decay_shift),
        .next_potential  (next_potential),
        .fire            (fire),
        .decay_exception (decay_exception),
        .add_exception   (add_exception),
        .spike           (spike)
    );

    // leak stage
    potential_decay u_decay (
        .potential       (potential),
        .decay_shift     (decay_shift),
        .decayed         (decayed),
        .decay_exception (decay_exception)
    );

    // integrate, compare, subtract-reset
    potential_adder u_adder (
        .decayed        (decayed),
        .weight         (weight),
        .threshold      (threshold),
        .next_potential (next_potential),
        .fire           (fire),
        .add_exception  (add_exception)
    );

endmodule

// ==== lif_neuron_regs.sv ====
// apb register file of the lif neuron with timestep sequencing and spike counting
`timescale 1ns/1ps
`include "neuron_defs.svh"

module lif_neuron_regs
    import neuron_pkg::*;
(
    input  logic         clk_adder,
    input  logic         rst_n,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  apb_addr_t    paddr,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    output fp32_t        potential,
    output fp32_t        weight,
    output fp32_t        threshold,
    output decay_shift_t decay_shift,
    input  fp32_t        next_potential,
    input  logic         fire,
    input  logic         decay_exception,
    input  logic         add_exception,
    output logic         spike
);

    reg_state_t   state;
    spike_count_t spike_count;
    logic         exc_flag;
    logic         access;
    logic         addr_hit;
    logic         wr_en;
    logic [31:0]  ctrl_rdata;
    logic [31:0]  rd_mux;

    // ****************************************
    // apb decode
    // ****************************************
    // no wait states
    assign access  = psel & penable;
    assign wr_en   = access & pwrite & addr_hit;
    assign pready  = 1'b1;
    assign pslverr = access & ~addr_hit;

    always_comb begin
        ctrl_rdata = '0;
        ctrl_rdata[`NEURON_DECAY_WIDTH-1:0] = decay_shift;
        ctrl_rdata[`NEURON_CTRL_EXC_BIT]    = exc_flag;
    end

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (paddr)
            `NEURON_ADDR_CTRL:      rd_mux = ctrl_rdata;
            `NEURON_ADDR_THRESHOLD: rd_mux = threshold;
            `NEURON_ADDR_WEIGHT:    rd_mux = weight;
            `NEURON_ADDR_POTENTIAL: rd_mux = potential;
            `NEURON_ADDR_SPIKES:    rd_mux = {16'd0, spike_count};
            default:                addr_hit = 1'b0;
        endcase
    end

    // read data only in a read access phase
    assign prdata = (access && !pwrite) ? rd_mux : '0;

    // ****************************************
    // registers and step flow
    // ****************************************
    always_ff @(posedge clk_adder or negedge rst_n) begin
        if (!rst_n) begin
            state       <= idle;
            potential   <= '0;
            weight      <= '0;
            threshold   <= `NEURON_THRESHOLD_RST;
            decay_shift <= `NEURON_DECAY_RST;
            spike_count <= '0;
            exc_flag    <= 1'b0;
            spike       <= 1'b0;
        end else begin
            // spike pulse lasts one cycle
            spike <= 1'b0;
            case (state)
                idle: begin
                    if (wr_en && paddr == `NEURON_ADDR_WEIGHT) begin
                        state <= step;
                    end
                end
                step: begin
                    // commit the timestep one cycle after the weight write
                    state     <= idle;
                    potential <= next_potential;
                    spike     <= fire;
                    if (fire) begin
                        spike_count <= spike_count + 1'b1;
                    end
                    exc_flag <= exc_flag | decay_exception | add_exception;
                end
                default: state <= idle;
            endcase
            // software writes, never in a step cycle
            if (wr_en) begin
                case (paddr)
                    `NEURON_ADDR_CTRL: begin
                        decay_shift <= pwdata[`NEURON_DECAY_WIDTH-1:0];
                        // write one to clear
                        if (pwdata[`NEURON_CTRL_EXC_BIT]) begin
                            exc_flag <= 1'b0;
                        end
                    end
                    `NEURON_ADDR_THRESHOLD: threshold   <= pwdata;
                    `NEURON_ADDR_WEIGHT:    weight      <= pwdata;
                    `NEURON_ADDR_POTENTIAL: potential   <= pwdata;
                    `NEURON_ADDR_SPIKES:    spike_count <= '0;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== neuron_defs.svh ====
// lif neuron register offsets, reset values and field widths
`ifndef NEURON_DEFS_SVH
`define NEURON_DEFS_SVH

// ****************************************
// field widths
// ****************************************
`define NEURON_FP_WIDTH       32
`define NEURON_DECAY_WIDTH    3
`define NEURON_COUNT_WIDTH    16
`define NEURON_ADDR_WIDTH     5
// sticky exception position in ctrl
`define NEURON_CTRL_EXC_BIT   8

// ****************************************
// register offsets and reset values
// ****************************************
`define NEURON_ADDR_CTRL      5'h00
`define NEURON_ADDR_THRESHOLD 5'h04
`define NEURON_ADDR_WEIGHT    5'h08
`define NEURON_ADDR_POTENTIAL 5'h0C
`define NEURON_ADDR_SPIKES    5'h10
// 40.0 in single precision
`define NEURON_THRESHOLD_RST  32'h42200000
`define NEURON_DECAY_RST      3'd3

`endif

// ==== neuron_pkg.sv ====
// shared types of the lif neuron: float words, leak shift, counter, address, step fsm
`include "neuron_defs.svh"

package neuron_pkg;

    // ieee-754 single word
    typedef logic [`NEURON_FP_WIDTH-1:0] fp32_t;

    // leak exponent, 0 disables the leak
    typedef logic [`NEURON_DECAY_WIDTH-1:0] decay_shift_t;

    // wrapping spike counter
    typedef logic [`NEURON_COUNT_WIDTH-1:0] spike_count_t;

    // apb register offset
    typedef logic [`NEURON_ADDR_WIDTH-1:0] apb_addr_t;

    // register block step flow
    typedef enum logic {idle, step} reg_state_t;

endpackage

// ==== potential_adder.sv ====
// weight integration, threshold compare and subtract-reset of the lif neuron
`timescale 1ns/1ps

module potential_adder
    import neuron_pkg::*;
(
    input  fp32_t decayed,
    input  fp32_t weight,
    input  fp32_t threshold,
    output fp32_t next_potential,
    output logic  fire,
    output logic  add_exception
);

    fp32_t sum;
    fp32_t reset_value;
    logic  sum_exception;
    logic  reset_exception;

    // float ordering, exponent 0 counts as zero so +0 equals -0
    function automatic logic fp_greater(input fp32_t x, input fp32_t y);
        logic x_zero;
        logic y_zero;
        x_zero = (x[30:23] == 8'd0);
        y_zero = (y[30:23] == 8'd0);
        if (x_zero && y_zero) begin
            return 1'b0;
        end else if (x_zero) begin
            return y[31];
        end else if (y_zero) begin
            return ~x[31];
        end else if (x[31] != y[31]) begin
            return y[31];
        end else if (x[31]) begin
            // both negative, smaller magnitude is greater
            return x[30:0] < y[30:0];
        end
        return x[30:0] > y[30:0];
    endfunction

    // decayed potential plus weight
    fp_add_sub u_weight_add (
        .a         (decayed),
        .b         (weight),
        .sub       (1'b0),
        .result    (sum),
        .exception (sum_exception)
    );

    // subtract-reset candidate
    fp_add_sub u_reset_sub (
        .a         (sum),
        .b         (threshold),
        .sub       (1'b1),
        .result    (reset_value),
        .exception (reset_exception)
    );

    assign fire           = fp_greater(sum, threshold);
    assign next_potential = fire ? reset_value : sum;
    assign add_exception  = sum_exception | reset_exception;

endmodule

// ==== potential_decay.sv ====
// membrane leak: subtracts the potential scaled by 2^-decay_shift
`timescale 1ns/1ps

module potential_decay
    import neuron_pkg::*;
(
    input  fp32_t        potential,
    input  decay_shift_t decay_shift,
    output fp32_t        decayed,
    output logic         decay_exception
);

    logic [7:0] pot_exp;
    fp32_t      leak;
    fp32_t      leaked;
    logic       sub_exception;

    assign pot_exp = potential[30:23];

    // leak term is the potential with the exponent lowered by the shift
    // too small to stay normal gives +0
    always_comb begin
        if (pot_exp > 8'(decay_shift)) begin
            leak = {potential[31], pot_exp - 8'(decay_shift), potential[22:0]};
        end else begin
            leak = '0;
        end
    end

    // v - v*2^-k
    fp_add_sub u_leak_sub (
        .a         (potential),
        .b         (leak),
        .sub       (1'b1),
        .result    (leaked),
        .exception (sub_exception)
    );

    // shift 0 means no leak at all
    assign decayed         = (decay_shift == '0) ? potential : leaked;
    assign decay_exception = (decay_shift != '0) & sub_exception;

endmodule

// ==== tb_fp_model.svh ====
// reference model of the lif neuron arithmetic: truncating float add/subtract, leak, timestep
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// a +/- b, exponent 0 as zero, truncated alignment, flush to +0, inf on overflow
task automatic model_add_sub(input fp32_t a, input fp32_t b, input logic sub,
                             output fp32_t r, output logic exc);
    int   ea;
    int   eb;
    int   ma;
    int   mb;
    int   e;
    int   m;
    int   t;
    logic sa;
    logic sb;
    logic st;
    sa  = a[31];
    sb  = b[31] ^ sub;
    ea  = a[30:23];
    eb  = b[30:23];
    ma  = (ea == 0) ? 0 : (int'(a[22:0]) + (1 << 23));
    mb  = (eb == 0) ? 0 : (int'(b[22:0]) + (1 << 23));
    exc = 1'b0;
    // keep the larger magnitude in a, ties stay
    if (eb > ea || (eb == ea && mb > ma)) begin
        t  = ea;
        ea = eb;
        eb = t;
        t  = ma;
        ma = mb;
        mb = t;
        st = sa;
        sa = sb;
        sb = st;
    end
    if (ea == 255 || eb == 255) begin
        // inf or nan operand, sign of the larger one
        exc = 1'b1;
        r   = {sa, 8'hff, 23'd0};
    end else begin
        e = ea - eb;
        mb = (e > 23) ? 0 : (mb >> e);
        m = (sa == sb) ? (ma + mb) : (ma - mb);
        e = ea;
        if (m >= (1 << 24)) begin
            m = m >> 1;
            e = e + 1;
        end
        while (m != 0 && m < (1 << 23)) begin
            m = m << 1;
            e = e - 1;
        end
        if (m == 0 || e <= 0) begin
            r = '0;
        end else if (e >= 255) begin
            exc = 1'b1;
            r   = {sa, 8'hff, 23'd0};
        end else begin
            r = {sa, 8'(e), m[22:0]};
        end
    end
endtask

// v - v*2^-shift, untouched for shift 0
task automatic model_leak(input fp32_t v, input int shift, output fp32_t d, output logic exc);
    fp32_t frac;
    int    ev;
    ev = v[30:23];
    if (shift == 0) begin
        d   = v;
        exc = 1'b0;
    end else begin
        // scaled copy leaves the normal range -> +0
        frac = (ev > shift) ? {v[31], 8'(ev - shift), v[22:0]} : 32'd0;
        model_add_sub(v, frac, 1'b1, d, exc);
    end
endtask

// signed ordering key, both zeros map to 0
function automatic longint order_key(input fp32_t x);
    if (x[30:23] == 8'd0) begin
        return 0;
    end
    return x[31] ? -longint'(x[30:0]) : longint'(x[30:0]);
endfunction

// one timestep: leak, integrate, compare, subtract-reset
task automatic model_step(input fp32_t pot, input int shift, input fp32_t w, input fp32_t thr,
                          output fp32_t next_pot, output logic fire, output logic exc);
    fp32_t dec;
    fp32_t sum;
    fp32_t diff;
    logic  e0;
    logic  e1;
    logic  e2;
    model_leak(pot, shift, dec, e0);
    model_add_sub(dec, w, 1'b0, sum, e1);
    model_add_sub(sum, thr, 1'b1, diff, e2);
    fire     = order_key(sum) > order_key(thr);
    next_pot = fire ? diff : sum;
    exc      = e0 | e1 | e2;
endtask

`endif

// ==== tb_lif_neuron.sv ====
// testbench of the lif neuron: random apb timesteps checked against a float model
`timescale 1ns/1ps
`include "neuron_defs.svh"

module tb_lif_neuron
    import neuron_pkg::*;
();

    localparam int  NUM_STEPS   = 300;
    localparam int  CLK_PERIOD  = 40;
    // steps plus directed ones, 10 cycles each, plus margin
    localparam time WATCHDOG_NS = (NUM_STEPS + 40) * 10 * CLK_PERIOD + 20000;

    logic         clk_adder;
    logic         rst_n;
    logic         psel;
    logic         penable;
    logic         pwrite;
    apb_addr_t    paddr;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;
    logic         spike;

    // model state
    fp32_t        m_pot;
    fp32_t        m_thr;
    fp32_t        m_weight;
    int           m_shift;
    spike_count_t m_count;
    logic         m_exc;

    int           seed;
    int           mismatch_count;
    int           other_count;
    logic [31:0]  r;
    logic         err;
    logic [31:0]  data;

    `include "tb_fp_model.svh"

    lif_neuron dut (
        .clk_adder (clk_adder),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .spike     (spike)
    );

    initial begin
        clk_adder = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adder = ~clk_adder;
    end

    // ****************************************
    // bus tasks and check helpers
    // ****************************************
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatch_count++;
        $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    endtask

    // setup, access, idle; status sampled mid access phase
    task automatic apb_write(input apb_addr_t addr, input logic [31:0] wdata, output logic bus_err);
        @(negedge clk_adder);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_adder);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        bus_err = pslverr;
        @(negedge clk_adder);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] rdata,
                            output logic bus_err);
        @(negedge clk_adder);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk_adder);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata   = prdata;
        bus_err = pslverr;
        @(negedge clk_adder);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_ok(input apb_addr_t addr, input logic [31:0] wdata);
        logic bus_err;
        apb_write(addr, wdata, bus_err);
        if (bus_err !== 1'b0) begin
            other_count++;
            $display("error at %0t ns: unexpected bus error on write to offset %h", $time, addr);
        end
    endtask

    task automatic read_expect(input apb_addr_t addr, input string name,
                               input logic [31:0] expected);
        logic [31:0] rdata;
        logic        bus_err;
        apb_read(addr, rdata, bus_err);
        if (bus_err !== 1'b0) begin
            other_count++;
            $display("error at %0t ns: unexpected bus error on read of offset %h", $time, addr);
        end
        if (rdata !== expected) report_mismatch(name, expected, rdata);
    endtask

    // all software-visible registers against the model
    task automatic check_status();
        read_expect(`NEURON_ADDR_CTRL, "ctrl", {23'd0, m_exc, 5'd0, 3'(m_shift)});
        read_expect(`NEURON_ADDR_THRESHOLD, "threshold", m_thr);
        read_expect(`NEURON_ADDR_WEIGHT, "weight", m_weight);
        read_expect(`NEURON_ADDR_POTENTIAL, "potential", m_pot);
        read_expect(`NEURON_ADDR_SPIKES, "spikes", {16'd0, m_count});
    endtask

    // weight write, one-cycle spike window, then potential readback
    task automatic run_step(input fp32_t w);
        fp32_t nxt;
        logic  fire;
        logic  exc;
        model_step(m_pot, m_shift, w, m_thr, nxt, fire, exc);
        write_ok(`NEURON_ADDR_WEIGHT, w);
        if (spike !== 1'b0) report_mismatch("spike", 32'd0, {31'd0, spike});
        @(negedge clk_adder);
        if (spike !== fire) report_mismatch("spike", {31'd0, fire}, {31'd0, spike});
        @(negedge clk_adder);
        if (spike !== 1'b0) report_mismatch("spike", 32'd0, {31'd0, spike});
        m_pot    = nxt;
        m_weight = w;
        m_exc    = m_exc | exc;
        if (fire) m_count = m_count + 1'b1;
        read_expect(`NEURON_ADDR_POTENTIAL, "potential", m_pot);
    endtask

    // mostly within +-64, some huge, infinite or zero-exponent
    function automatic fp32_t random_weight();
        logic [31:0] bits;
        int          sel;
        int          e;
        bits = $random(seed);
        sel  = {$random(seed)} % 64;
        if (sel == 0) return {bits[31], 8'hff, 23'd0};
        if (sel < 4) begin
            e = 240 + {$random(seed)} % 15;
        end else if (sel < 6) begin
            e = 0;
        end else begin
            e = 117 + {$random(seed)} % 16;
        end
        return {bits[31], 8'(e), bits[22:0]};
    endfunction

    // ****************************************
    // stimulus
    // ****************************************
    initial begin
        rst_n          = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        seed           = 66;
        mismatch_count = 0;
        other_count    = 0;
        m_pot          = '0;
        m_thr          = `NEURON_THRESHOLD_RST;
        m_weight       = '0;
        m_shift        = 3;
        m_count        = '0;
        m_exc          = 1'b0;
        repeat (4) @(negedge clk_adder);
        rst_n = 1'b1;

        // reset values
        if (spike !== 1'b0) report_mismatch("spike", 32'd0, {31'd0, spike});
        if (prdata !== 32'd0) report_mismatch("prdata", 32'd0, prdata);
        if (pslverr !== 1'b0) report_mismatch("pslverr", 32'd0, {31'd0, pslverr});
        if (pready !== 1'b1) report_mismatch("pready", 32'd1, {31'd0, pready});
        check_status();

        // random timesteps
        for (int i = 0; i < NUM_STEPS; i++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                m_shift = r[10:8];
                write_ok(`NEURON_ADDR_CTRL, {29'd0, 3'(m_shift)});
            end
            if (r[6:3] == 4'd0) begin
                m_thr = {1'b0, 8'(130 + int'(r[12:11])), r[30:8]};
                write_ok(`NEURON_ADDR_THRESHOLD, m_thr);
            end
            run_step(random_weight());
            // infinite potential never recovers, reload it
            if (m_pot[30:23] == 8'hff) begin
                r     = $random(seed);
                m_pot = {r[31], 8'(120 + int'(r[3:0])), r[26:4]};
                write_ok(`NEURON_ADDR_POTENTIAL, m_pot);
                read_expect(`NEURON_ADDR_POTENTIAL, "potential", m_pot);
            end
            if (i % 50 == 49) begin
                check_status();
                if (m_exc) begin
                    write_ok(`NEURON_ADDR_CTRL, 32'h100 | m_shift);
                    m_exc = 1'b0;
                end
            end
        end

        // spike counter clear
        read_expect(`NEURON_ADDR_SPIKES, "spikes", {16'd0, m_count});
        write_ok(`NEURON_ADDR_SPIKES, 32'hffff_ffff);
        m_count = '0;
        read_expect(`NEURON_ADDR_SPIKES, "spikes", 32'd0);

        // sticky exception: infinite weight, later clean step, write-one clear
        write_ok(`NEURON_ADDR_CTRL, 32'h100 | m_shift);
        m_exc = 1'b0;
        check_status();
        run_step(32'hff80_0000);
        check_status();
        m_pot = 32'h3f80_0000;
        write_ok(`NEURON_ADDR_POTENTIAL, m_pot);
        run_step(32'h3f80_0000);
        check_status();
        write_ok(`NEURON_ADDR_CTRL, 32'h100 | m_shift);
        m_exc = 1'b0;
        check_status();
        // overflowing sum with no leak
        m_shift = 0;
        write_ok(`NEURON_ADDR_CTRL, 32'd0);
        m_pot = 32'h7f00_0000;
        write_ok(`NEURON_ADDR_POTENTIAL, m_pot);
        run_step(32'h7f00_0000);
        check_status();

        // potential override then a step on top of it
        m_shift = 3;
        write_ok(`NEURON_ADDR_CTRL, 32'h103);
        m_exc = 1'b0;
        m_pot = 32'h4120_0000;
        write_ok(`NEURON_ADDR_POTENTIAL, m_pot);
        read_expect(`NEURON_ADDR_POTENTIAL, "potential", m_pot);
        run_step(32'h4020_0000);

        // unmapped offsets answer with pslverr and change nothing
        apb_read(5'h14, data, err);
        if (err !== 1'b1) report_mismatch("pslverr", 32'd1, {31'd0, err});
        apb_write(5'h1c, 32'hdead_beef, err);
        if (err !== 1'b1) report_mismatch("pslverr", 32'd1, {31'd0, err});
        check_status();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
neuron_pkg.sv
fp_add_sub.sv
potential_decay.sv
potential_adder.sv
lif_neuron_regs.sv
lif_neuron.sv
tb_lif_neuron.sv
